/* source/gpio_pkg.sv */
/*
 * GPIO subsystem shared definitions
 * bus widths, register map and bank map constants
 * used by the decoder, the banks and the top level
 */

package gpio_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // data path of the system bus
  localparam int unsigned data_width = 32;
  // byte address, covers both banks plus unmapped space
  localparam int unsigned addr_width = 8;

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_width-1:0] addr_t;

  //////////////////////////////////////////////////
  // register map inside one bank
  //////////////////////////////////////////////////

  // word index sits above the byte lanes
  localparam int unsigned reg_idx_lsb   = 2;
  localparam int unsigned reg_idx_width = 2;

  typedef logic [reg_idx_width-1:0] reg_idx_t;

  // output register
  localparam reg_idx_t reg_out_idx = 2'd0;
  // output enable register
  localparam reg_idx_t reg_oe_idx  = 2'd1;
  // synchronized pin levels, read only
  localparam reg_idx_t reg_pin_idx = 2'd2;
  // index 3 reserved, reads zero

  //////////////////////////////////////////////////
  // bank map
  //////////////////////////////////////////////////

  localparam int unsigned bank_span  = 16;
  localparam int unsigned bank_count = 2;

  // bank select bits right above the register index
  localparam int unsigned bank_sel_lsb   = $clog2(bank_span);
  localparam int unsigned bank_sel_width = $clog2(bank_count);
  // first byte address past the last bank
  localparam int unsigned map_limit      = bank_span * bank_count;

  typedef logic [bank_sel_width-1:0] bank_sel_t;

endpackage

/* source/gpio_sync.sv */
/*
 * GPIO input synchronizer
 * chain of flip-flop rows that brings asynchronous
 * pin levels into the bus clock domain
 */

module gpio_sync #(
  parameter int unsigned width  = 8,
  parameter int unsigned stages = 2
)(
  input  logic             bus,
  input  logic             arst_n,
  input  logic [width-1:0] async_in,
  output logic [width-1:0] sync_out
);

  // fewer than two rows gives no metastability margin
  if (stages < 2) begin : gen_stages_check
    $error("gpio_sync: stages %0d below minimum of 2", stages);
  end

  //////////////////////////////////////////////////
  // flip-flop chain
  //////////////////////////////////////////////////

  // row 0 samples the pins, last row feeds the bank
  logic [stages-1:0][width-1:0] stage_q;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      stage_q <= '0;
    end else begin
      // shift one row per edge
      stage_q[0] <= async_in;
      for (int i = 1; i < stages; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // pin level after stages edges
  assign sync_out = stage_q[stages-1];

endmodule

/* source/gpio_regs.sv */
/*
 * GPIO bank
 * output and output enable registers, synchronized
 * pin readback and a registered read data mux
 */

module gpio_regs
  import gpio_pkg::*;
#(
  parameter int unsigned width       = 16,
  parameter int unsigned sync_stages = 2
)(
  input  logic             bus,
  input  logic             arst_n,
  // transfer from the decoder
  input  logic             trn,
  input  logic             wen,
  input  reg_idx_t         reg_idx,
  input  data_t            wdt,
  output data_t            rdt,
  // pins
  output logic [width-1:0] drive,
  output logic [width-1:0] enable,
  input  logic [width-1:0] pins
);

  // bank must fit the data bus
  if ((width < 1) || (width > data_width)) begin : gen_width_check
    $error("gpio_regs: width %0d outside 1 to %0d", width, data_width);
  end

  //////////////////////////////////////////////////
  // pin input synchronization
  //////////////////////////////////////////////////

  // pin levels in the bus clock domain
  logic [width-1:0] pins_sync;

  gpio_sync #(
    .width  (width),
    .stages (sync_stages)
  ) u_sync (
    .bus      (bus),
    .arst_n   (arst_n),
    .async_in (pins),
    .sync_out (pins_sync)
  );

  //////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////

  // bank width slice of the write data
  logic [width-1:0] wdt_bank;

  assign wdt_bank = wdt[width-1:0];

  // pin outputs follow the registers directly
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      drive  <= '0;
      enable <= '0;
    end else if (trn && wen) begin
      case (reg_idx)
        reg_out_idx: drive  <= wdt_bank;
        reg_oe_idx:  enable <= wdt_bank;
        // pin readback and reserved index ignore writes
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  // selected register, zero extended
  data_t rd_val;

  always_comb begin
    rd_val = '0;
    case (reg_idx)
      reg_out_idx: rd_val[width-1:0] = drive;
      reg_oe_idx:  rd_val[width-1:0] = enable;
      reg_pin_idx: rd_val[width-1:0] = pins_sync;
      // reserved reads zero
      default:     rd_val = '0;
    endcase
  end

  // one cycle read latency
  // value held until the next read of this bank
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rdt <= '0;
    end else if (trn && !wen) begin
      rdt <= rd_val;
    end
  end

endmodule

/* source/bus_decoder.sv */
/*
 * GPIO bus decoder
 * splits one transfer port between the banks, flags
 * out of map transfers and steers the read data back
 */

module bus_decoder
  import gpio_pkg::*;
(
  input  logic     bus,
  input  logic     arst_n,
  // upstream transfer
  input  logic     trn,
  input  logic     wen,
  input  addr_t    adr,
  output data_t    rdt,
  output logic     err,
  // bank side
  output logic     bank0_trn,
  output logic     bank1_trn,
  output reg_idx_t reg_idx,
  input  data_t    bank0_rdt,
  input  data_t    bank1_rdt
);

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////

  bank_sel_t bank_sel;
  logic      in_map;

  // byte lane bits 1:0 are dropped
  assign reg_idx  = adr[reg_idx_lsb +: reg_idx_width];
  assign bank_sel = adr[bank_sel_lsb +: bank_sel_width];

  // anything at or past map_limit hits no bank
  assign in_map = (int'(adr) < map_limit);

  // strobe only the addressed bank
  assign bank0_trn = trn && in_map && (bank_sel == bank_sel_t'(0));
  assign bank1_trn = trn && in_map && (bank_sel == bank_sel_t'(1));

  //////////////////////////////////////////////////
  // error response
  //////////////////////////////////////////////////

  // one cycle pulse, reads and writes alike
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      err <= 1'b0;
    end else begin
      err <= trn && !in_map;
    end
  end

  //////////////////////////////////////////////////
  // read data steering
  //////////////////////////////////////////////////

  // source of the last read
  bank_sel_t rd_sel_q;
  // last read went out of map
  logic      rd_oom_q;

  // writes leave the selection alone so rdt holds
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rd_sel_q <= '0;
      rd_oom_q <= 1'b1;
    end else if (trn && !wen) begin
      rd_sel_q <= bank_sel;
      rd_oom_q <= !in_map;
    end
  end

  // banks already registered their data
  always_comb begin
    if (rd_oom_q) begin
      // out of map reads zero
      rdt = '0;
    end else if (rd_sel_q == bank_sel_t'(0)) begin
      rdt = bank0_rdt;
    end else begin
      rdt = bank1_rdt;
    end
  end

endmodule

/* source/gpio_subsys.sv */
/*
 * GPIO subsystem top level
 * bus decoder in front of two GPIO banks
 * of independent widths
 */

module gpio_subsys
  import gpio_pkg::*;
#(
  parameter int unsigned gpio0_width = 16,
  parameter int unsigned gpio1_width = 8,
  parameter int unsigned sync_stages = 2
)(
  input  logic                   bus,
  input  logic                   arst_n,
  // system bus
  input  logic                   trn,
  input  logic                   wen,
  input  addr_t                  adr,
  input  data_t                  wdt,
  output data_t                  rdt,
  output logic                   err,
  // bank 0 pins
  output logic [gpio0_width-1:0] gpio0_drive,
  output logic [gpio0_width-1:0] gpio0_enable,
  input  logic [gpio0_width-1:0] gpio0_pins,
  // bank 1 pins
  output logic [gpio1_width-1:0] gpio1_drive,
  output logic [gpio1_width-1:0] gpio1_enable,
  input  logic [gpio1_width-1:0] gpio1_pins
);

  // decoder to bank wiring
  logic     bank0_trn;
  logic     bank1_trn;
  reg_idx_t reg_idx;
  data_t    bank0_rdt;
  data_t    bank1_rdt;

  //////////////////////////////////////////////////
  // address decode and read steering
  //////////////////////////////////////////////////

  bus_decoder u_decoder (
    .bus       (bus),
    .arst_n    (arst_n),
    .trn       (trn),
    .wen       (wen),
    .adr       (adr),
    .rdt       (rdt),
    .err       (err),
    .bank0_trn (bank0_trn),
    .bank1_trn (bank1_trn),
    .reg_idx   (reg_idx),
    .bank0_rdt (bank0_rdt),
    .bank1_rdt (bank1_rdt)
  );

  //////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////

  // bytes 0x00 to 0x0f
  gpio_regs #(
    .width       (gpio0_width),
    .sync_stages (sync_stages)
  ) u_bank0 (
    .bus     (bus),
    .arst_n  (arst_n),
    .trn     (bank0_trn),
    .wen     (wen),
    .reg_idx (reg_idx),
    .wdt     (wdt),
    .rdt     (bank0_rdt),
    .drive   (gpio0_drive),
    .enable  (gpio0_enable),
    .pins    (gpio0_pins)
  );

  // bytes 0x10 to 0x1f
  gpio_regs #(
    .width       (gpio1_width),
    .sync_stages (sync_stages)
  ) u_bank1 (
    .bus     (bus),
    .arst_n  (arst_n),
    .trn     (bank1_trn),
    .wen     (wen),
    .reg_idx (reg_idx),
    .wdt     (wdt),
    .rdt     (bank1_rdt),
    .drive   (gpio1_drive),
    .enable  (gpio1_enable),
    .pins    (gpio1_pins)
  );

endmodule

/* verification/gpio_subsys_checker.sv */
/*
 * GPIO subsystem checker
 * concurrent assertions on the bus response and the
 * bank 0 pin outputs, bound into the top level
 */

module gpio_subsys_checker
  import gpio_pkg::*;
#(
  parameter int unsigned gpio0_width = 16,
  parameter int unsigned gpio1_width = 8
)(
  input logic                   bus,
  input logic                   arst_n,
  input logic                   trn,
  input logic                   wen,
  input addr_t                  adr,
  input data_t                  wdt,
  input data_t                  rdt,
  input logic                   err,
  input logic [gpio0_width-1:0] gpio0_drive,
  input logic [gpio0_width-1:0] gpio0_enable,
  input logic [gpio1_width-1:0] gpio1_drive,
  input logic [gpio1_width-1:0] gpio1_enable
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // write to the bank 0 output register
  logic out0_write;

  assign out0_write = trn && wen && (int'(adr) < bank_span) &&
                      (adr[reg_idx_lsb +: reg_idx_width] == reg_out_idx);

  //////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////

  // error pulse only follows a transfer edge
  err_after_transfer: assert property (
    @(posedge bus) disable iff (!arst_n) err |-> $past(trn)
  ) else begin
    fail_count = fail_count + 1;
    $error("err high without a transfer in the previous cycle");
  end

  // read data known once a read completed
  rdt_known_after_read: assert property (
    @(posedge bus) disable iff (!arst_n) $past(trn && !wen) |-> !$isunknown(rdt)
  ) else begin
    fail_count = fail_count + 1;
    $error("rdt unknown after a read");
  end

  //////////////////////////////////////////////////
  // pin outputs and reset
  //////////////////////////////////////////////////

  // output register reaches the pins at the write edge
  drive_follows_write: assert property (
    @(posedge bus) disable iff (!arst_n)
    $past(out0_write) |-> (gpio0_drive == $past(wdt[gpio0_width-1:0]))
  ) else begin
    fail_count = fail_count + 1;
    $error("gpio0_drive does not match the written value");
  end

  // all outputs cleared while reset is held
  zero_in_reset: assert property (
    @(posedge bus) !arst_n |-> (rdt == '0) && !err &&
      (gpio0_drive == '0) && (gpio0_enable == '0) &&
      (gpio1_drive == '0) && (gpio1_enable == '0)
  ) else begin
    fail_count = fail_count + 1;
    $error("outputs not zero during reset");
  end

endmodule

/* verification/gpio_subsys_tb.sv */
/*
 * GPIO subsystem testbench
 * drives the system bus and the pins, models both banks
 * and compares every response against that model
 */

module gpio_subsys_tb
  import gpio_pkg::*;
();

  localparam int unsigned gpio0_width     = 16;
  localparam int unsigned gpio1_width     = 8;
  localparam int unsigned sync_stages     = 2;
  localparam int unsigned clk_period      = 40;
  localparam int unsigned reset_cycles    = 5;
  localparam int unsigned random_count    = 200;
  // directed tests with their idle gaps
  localparam int unsigned directed_cycles = 150;
  localparam int unsigned margin_cycles   = 50;
  localparam int unsigned timeout_time    =
    (reset_cycles + directed_cycles + random_count + margin_cycles) * clk_period;

  localparam data_t gpio0_mask = data_t'((64'd1 << gpio0_width) - 64'd1);
  localparam data_t gpio1_mask = data_t'((64'd1 << gpio1_width) - 64'd1);

  logic bus;
  logic arst_n;
  logic trn;
  logic wen;
  addr_t adr;
  data_t wdt;
  data_t rdt;
  logic err;
  logic [gpio0_width-1:0] gpio0_drive;
  logic [gpio0_width-1:0] gpio0_enable;
  logic [gpio0_width-1:0] gpio0_pins;
  logic [gpio1_width-1:0] gpio1_drive;
  logic [gpio1_width-1:0] gpio1_enable;
  logic [gpio1_width-1:0] gpio1_pins;

  integer      seed        = 32'h2be3_a4d8;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  logic        reset_done  = 1'b0;

  // register model masked to the bank widths
  data_t model_out0 = '0;
  data_t model_oe0  = '0;
  data_t model_pin0 = '0;
  data_t model_out1 = '0;
  data_t model_oe1  = '0;
  data_t model_pin1 = '0;

  gpio_subsys #(
    .gpio0_width (gpio0_width),
    .gpio1_width (gpio1_width),
    .sync_stages (sync_stages)
  ) u_dut (
    .bus          (bus),
    .arst_n       (arst_n),
    .trn          (trn),
    .wen          (wen),
    .adr          (adr),
    .wdt          (wdt),
    .rdt          (rdt),
    .err          (err),
    .gpio0_drive  (gpio0_drive),
    .gpio0_enable (gpio0_enable),
    .gpio0_pins   (gpio0_pins),
    .gpio1_drive  (gpio1_drive),
    .gpio1_enable (gpio1_enable),
    .gpio1_pins   (gpio1_pins)
  );

  bind gpio_subsys gpio_subsys_checker #(
    .gpio0_width (gpio0_width),
    .gpio1_width (gpio1_width)
  ) u_checker (
    .bus          (bus),
    .arst_n       (arst_n),
    .trn          (trn),
    .wen          (wen),
    .adr          (adr),
    .wdt          (wdt),
    .rdt          (rdt),
    .err          (err),
    .gpio0_drive  (gpio0_drive),
    .gpio0_enable (gpio0_enable),
    .gpio1_drive  (gpio1_drive),
    .gpio1_enable (gpio1_enable)
  );

  initial begin : clock_gen
    bus = 1'b0;
    forever begin
      #(clk_period / 2) bus = ~bus;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // 0x20 and above hits no bank
  function automatic logic model_err(input addr_t a);
    return (a >= 8'h20);
  endfunction

  function automatic data_t model_read(input addr_t a);
    data_t    val;
    reg_idx_t idx;
    logic     hi;
    val = '0;
    idx = a[3:2];
    hi  = (a >= 8'h10);
    if (!model_err(a)) begin
      case (idx)
        reg_out_idx: val = hi ? model_out1 : model_out0;
        reg_oe_idx:  val = hi ? model_oe1 : model_oe0;
        reg_pin_idx: val = hi ? model_pin1 : model_pin0;
        default:     val = '0;
      endcase
    end
    return val;
  endfunction

  // pin index, reserved index and out of map writes are dropped
  function automatic void model_write(input addr_t a, input data_t d);
    if (!model_err(a)) begin
      if (a[3:2] == reg_out_idx) begin
        if (a >= 8'h10) model_out1 = d & gpio1_mask;
        else model_out0 = d & gpio0_mask;
      end else if (a[3:2] == reg_oe_idx) begin
        if (a >= 8'h10) model_oe1 = d & gpio1_mask;
        else model_oe0 = d & gpio0_mask;
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_data(input string what, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // transfer sampled at the rising edge and outputs checked at the falling edge
  initial begin : compare_proc
    logic  s_trn;
    logic  s_wen;
    addr_t s_adr;
    data_t exp_rdt;
    logic  exp_err;
    exp_rdt = '0;
    wait (reset_done === 1'b1);
    forever begin
      @(posedge bus);
      s_trn   = trn;
      s_wen   = wen;
      s_adr   = adr;
      exp_err = s_trn && model_err(s_adr);
      // rdt holds between reads
      if (s_trn && !s_wen) exp_rdt = model_read(s_adr);
      if (s_trn && s_wen) model_write(s_adr, wdt);
      @(negedge bus);
      check_data("rdt", rdt, exp_rdt);
      check_err("err", err, exp_err);
      check_data("gpio0_drive", data_t'(gpio0_drive), model_out0);
      check_data("gpio0_enable", data_t'(gpio0_enable), model_oe0);
      check_data("gpio1_drive", data_t'(gpio1_drive), model_out1);
      check_data("gpio1_enable", data_t'(gpio1_enable), model_oe1);
    end
  end

  //////////////////////////////////////////////////
  // bus and pin drivers, falling edge
  //////////////////////////////////////////////////

  task automatic bus_write(input addr_t a, input data_t d);
    @(negedge bus);
    trn = 1'b1;
    wen = 1'b1;
    adr = a;
    wdt = d;
  endtask

  task automatic bus_read(input addr_t a);
    @(negedge bus);
    trn = 1'b1;
    wen = 1'b0;
    adr = a;
    wdt = '0;
  endtask

  task automatic bus_idle(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge bus);
      trn = 1'b0;
      wen = 1'b0;
    end
  endtask

  // new pin levels with the bus idle, then wait out the synchronizer
  task automatic drive_pins();
    @(negedge bus);
    trn        = 1'b0;
    wen        = 1'b0;
    gpio0_pins = gpio0_width'($random(seed));
    gpio1_pins = gpio1_width'($random(seed));
    model_pin0 = data_t'(gpio0_pins);
    model_pin1 = data_t'(gpio1_pins);
    bus_idle(sync_stages + 1);
  endtask

  task automatic report_test(input string name, input int unsigned errs_at_start);
    $display("test %s done, %0d errors", name, error_count - errs_at_start);
  endtask

  initial begin : watchdog
    #(timeout_time);
    $display("watchdog expired after %0d time units, run did not complete", timeout_time);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main_proc
    int unsigned errs_at_start;
    int unsigned total_errors;
    addr_t       a;
    arst_n     = 1'b1;
    trn        = 1'b0;
    wen        = 1'b0;
    adr        = '0;
    wdt        = '0;
    gpio0_pins = '0;
    gpio1_pins = '0;
    @(negedge bus);
    arst_n = 1'b0;
    repeat (reset_cycles) @(negedge bus);
    arst_n     = 1'b1;
    reset_done = 1'b1;

    // 1 every index of both banks reads zero
    errs_at_start = error_count;
    for (int i = 0; i < 4; i++) begin
      bus_read(addr_t'(4 * i));
      bus_read(addr_t'(8'h10 + 4 * i));
    end
    bus_idle(2);
    report_test("reset_values", errs_at_start);

    // 2 output and enable registers, random data
    errs_at_start = error_count;
    for (int r = 0; r < 4; r++) begin
      a = (r % 2 == 0) ? 8'h00 : 8'h10;
      bus_write(a, $random(seed));
      bus_write(a + 8'h04, $random(seed));
      bus_read(a);
      bus_read(a + 8'h04);
    end
    bus_idle(2);
    report_test("write_read", errs_at_start);

    // 3 pin readback, index 2 ignores writes
    errs_at_start = error_count;
    for (int r = 0; r < 2; r++) begin
      drive_pins();
      bus_read(8'h08);
      bus_read(8'h18);
      bus_write(8'h08, $random(seed));
      bus_write(8'h18, $random(seed));
      bus_read(8'h08);
      bus_read(8'h18);
    end
    bus_idle(2);
    report_test("pin_readback", errs_at_start);

    // 4 reserved index and out of map
    errs_at_start = error_count;
    bus_read(8'h0c);
    bus_write(8'h1c, $random(seed));
    bus_read(8'h1c);
    for (int r = 0; r < 4; r++) begin
      a = addr_t'(8'h20 + ($unsigned($random(seed)) % 8'he0));
      bus_read(8'h00);
      bus_read(a);
      bus_write(a, $random(seed));
    end
    bus_read(8'h00);
    bus_read(8'h04);
    bus_read(8'h10);
    bus_read(8'h14);
    bus_idle(2);
    report_test("reserved_unmapped", errs_at_start);

    // 5 back to back random transfers including out of map
    errs_at_start = error_count;
    for (int n = 0; n < random_count; n++) begin
      a = addr_t'($unsigned($random(seed)) % 48);
      if ($random(seed) & 1) bus_write(a, $random(seed));
      else bus_read(a);
    end
    bus_idle(2);
    report_test("random_mixed", errs_at_start);

    total_errors = error_count + u_dut.u_checker.fail_count;
    $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, u_dut.u_checker.fail_count);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* gpio_subsys.f */
source/gpio_pkg.sv
source/gpio_sync.sv
source/gpio_regs.sv
source/bus_decoder.sv
source/gpio_subsys.sv
verification/gpio_subsys_checker.sv
verification/gpio_subsys_tb.sv
